//--- rtl/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// machine word, also used as the address width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32

// rs1, rs2 and rd fields are all this wide
`define RV_REG_IDX_W 5

// fetch starts here after reset
`define RV_RESET_PC 32'h0000_0000

// sequential fetch moves one word at a time
`define RV_PC_STEP 32'd4

`endif

//--- rtl/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_STORE  = 7'b010_0011,
    OPC_BRANCH = 7'b110_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WB   = 2'd2
  } fwd_sel_e;

  // zero is left unused so an undriven trace stands out
  typedef enum logic [2:0] {
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd3,
    CYCLE_LOAD2USE     = 3'd4
  } cycle_status_e;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    cycle_status_e status;
  } decode_stage_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    cycle_status_e status;
  } execute_stage_t;

  // also the writeback shape, with store_data holding the loaded word there
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] store_data;
    logic rd_we;
    cycle_status_e status;
  } memory_stage_t;

endpackage

//--- rtl/hazard_if.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

interface hazard_if;

  // register indices, zero when the stage does not read or write one
  logic [`RV_REG_IDX_W-1:0] dec_rs1;
  logic [`RV_REG_IDX_W-1:0] dec_rs2;
  logic [`RV_REG_IDX_W-1:0] ex_rs1;
  logic [`RV_REG_IDX_W-1:0] ex_rs2;
  logic [`RV_REG_IDX_W-1:0] ex_rd;
  logic [`RV_REG_IDX_W-1:0] mem_rs2;
  logic [`RV_REG_IDX_W-1:0] mem_rd;
  logic [`RV_REG_IDX_W-1:0] wb_rd;
  logic ex_is_load;
  logic branch_taken;
  logic mem_we;
  logic wb_we;

  // decisions
  logic stall;
  logic flush;
  logic store_fwd;
  rv_pkg::fwd_sel_e fwd_a;
  rv_pkg::fwd_sel_e fwd_b;

  modport dp (
    output dec_rs1, dec_rs2, ex_rs1, ex_rs2, ex_rd, ex_is_load, branch_taken,
    output mem_rs2, mem_rd, mem_we, wb_rd, wb_we,
    input stall, flush, fwd_a, fwd_b, store_fwd
  );

  modport ctrl (
    input dec_rs1, dec_rs2, ex_rs1, ex_rs2, ex_rd, ex_is_load, branch_taken,
    input mem_rs2, mem_rd, mem_we, wb_rd, wb_we,
    output stall, flush, fwd_a, fwd_b, store_fwd
  );

endinterface

//--- rtl/hazard_ctrl.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module hazard_ctrl (
  input logic clk,
  input logic rst,
  hazard_if.ctrl hz
);

  // a producer matches when it writes a nonzero rd equal to the source index
  function automatic logic hits(
    input logic we,
    input logic [`RV_REG_IDX_W-1:0] rd,
    input logic [`RV_REG_IDX_W-1:0] rs
  );
    hits = we && (rd != '0) && (rd == rs);
  endfunction

  // load data only exists after memory, so the consumer waits one cycle
  assign hz.stall = hz.ex_is_load &&
                    (hits(1'b1, hz.ex_rd, hz.dec_rs1) || hits(1'b1, hz.ex_rd, hz.dec_rs2));

  // branch resolves in execute, both younger stages are wrong-path
  assign hz.flush = hz.branch_taken;

  // memory holds the younger producer and wins over writeback
  assign hz.fwd_a = hits(hz.mem_we, hz.mem_rd, hz.ex_rs1) ? rv_pkg::FWD_MEM :
                    hits(hz.wb_we, hz.wb_rd, hz.ex_rs1)   ? rv_pkg::FWD_WB  :
                                                            rv_pkg::FWD_NONE;

  assign hz.fwd_b = hits(hz.mem_we, hz.mem_rd, hz.ex_rs2) ? rv_pkg::FWD_MEM :
                    hits(hz.wb_we, hz.wb_rd, hz.ex_rs2)   ? rv_pkg::FWD_WB  :
                                                            rv_pkg::FWD_NONE;

  // store data register written by the instruction just ahead of the store
  assign hz.store_fwd = hits(hz.wb_we, hz.wb_rd, hz.mem_rs2);

  // a load in execute and a taken branch in execute cannot coexist
  a_stall_flush_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(hz.stall && hz.flush)
  ) else $error("stall and flush asserted together");

  // a load moved to memory last edge, its result field is only an address
  a_no_mem_fwd_of_load: assert property (
    @(posedge clk) disable iff (rst)
    $past(hz.ex_is_load) |-> hz.fwd_a != rv_pkg::FWD_MEM
  ) else $error("operand a forwarded from a load still in memory");

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module fetch_unit (
  input  logic clk,
  input  logic rst,
  hazard_if.dp hz,
  input  logic [`RV_XLEN-1:0] redirect_pc,
  input  logic [`RV_XLEN-1:0] insn_from_imem,
  output logic [`RV_XLEN-1:0] pc_to_imem,
  output rv_pkg::decode_stage_t decode_state
);

  logic [`RV_XLEN-1:0] pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
      decode_state <= '{pc: '0, insn: '0, status: rv_pkg::CYCLE_RESET};
    end else if (hz.flush) begin
      pc <= redirect_pc;
      decode_state <= '{pc: '0, insn: '0, status: rv_pkg::CYCLE_TAKEN_BRANCH};
    end else if (!hz.stall) begin
      pc <= pc + `RV_PC_STEP;
      decode_state <= '{pc: pc, insn: insn_from_imem, status: rv_pkg::CYCLE_NO_STALL};
    end
  end

  assign pc_to_imem = pc;

  // only report sources the instruction really reads
  assign hz.dec_rs1 = (decode_state.insn[6:0] inside {
                        rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH,
                        rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP})
                      ? decode_state.insn[19:15] : '0;
  assign hz.dec_rs2 = (decode_state.insn[6:0] inside {
                        rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH, rv_pkg::OPC_OP})
                      ? decode_state.insn[24:20] : '0;

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module reg_file (
  input  logic clk,
  input  logic rst,
  input  logic [`RV_REG_IDX_W-1:0] rs1,
  input  logic [`RV_REG_IDX_W-1:0] rs2,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_REG_IDX_W-1:0] rd,
  input  logic [`RV_XLEN-1:0] rd_data,
  input  logic we
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // x0 reads zero, a same-cycle write is passed straight through
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_IDX_W-1:0] idx);
    if (idx == '0) begin
      read_port = '0;
    end else if (we && rd == idx) begin
      read_port = rd_data;
    end else begin
      read_port = regs[idx];
    end
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module exec_unit (
  input  logic clk,
  input  logic rst,
  hazard_if.dp hz,
  input  rv_pkg::decode_stage_t decode_state,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_REG_IDX_W-1:0] rf_rs1,
  output logic [`RV_REG_IDX_W-1:0] rf_rs2,
  input  logic [`RV_XLEN-1:0] wb_result,
  output logic [`RV_XLEN-1:0] redirect_pc,
  output rv_pkg::memory_stage_t memory_state
);

  rv_pkg::execute_stage_t ex;
  rv_pkg::opcode_e opcode;
  rv_pkg::alu_op_e alu_op;
  logic [2:0] funct3;
  logic alt;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] fwd_b_val;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic rd_we;

  function automatic logic [`RV_XLEN-1:0] fwd_mux(
    input rv_pkg::fwd_sel_e sel,
    input logic [`RV_XLEN-1:0] latched,
    input logic [`RV_XLEN-1:0] mem_val,
    input logic [`RV_XLEN-1:0] wb_val
  );
    case (sel)
      rv_pkg::FWD_MEM: fwd_mux = mem_val;
      rv_pkg::FWD_WB:  fwd_mux = wb_val;
      default:         fwd_mux = latched;
    endcase
  endfunction

  assign rf_rs1 = decode_state.insn[19:15];
  assign rf_rs2 = decode_state.insn[24:20];

  always_ff @(posedge clk) begin
    if (rst) begin
      ex <= '{pc: '0, insn: '0, a: '0, b: '0, status: rv_pkg::CYCLE_RESET};
    end else if (hz.flush) begin
      ex <= '{pc: '0, insn: '0, a: '0, b: '0, status: rv_pkg::CYCLE_TAKEN_BRANCH};
    end else if (hz.stall) begin
      ex <= '{pc: '0, insn: '0, a: '0, b: '0, status: rv_pkg::CYCLE_LOAD2USE};
    end else begin
      ex <= '{pc: decode_state.pc, insn: decode_state.insn, a: rs1_data, b: rs2_data,
              status: decode_state.status};
    end
  end

  assign opcode = rv_pkg::opcode_e'(ex.insn[6:0]);
  assign funct3 = ex.insn[14:12];
  // funct7 bit 5 picks SUB and SRA
  assign alt = ex.insn[30];

  assign imm_i = {{20{ex.insn[31]}}, ex.insn[31:20]};
  assign imm_s = {{20{ex.insn[31]}}, ex.insn[31:25], ex.insn[11:7]};
  assign imm_b = {{19{ex.insn[31]}}, ex.insn[31], ex.insn[7], ex.insn[30:25],
                  ex.insn[11:8], 1'b0};
  assign imm_u = {ex.insn[31:12], 12'b0};

  assign hz.ex_rs1 = (opcode inside {rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH,
                                     rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP})
                     ? ex.insn[19:15] : '0;
  assign hz.ex_rs2 = (opcode inside {rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH, rv_pkg::OPC_OP})
                     ? ex.insn[24:20] : '0;
  assign hz.ex_rd = ex.insn[11:7];
  assign hz.ex_is_load = (opcode == rv_pkg::OPC_LOAD);

  assign op_a = fwd_mux(hz.fwd_a, ex.a, memory_state.result, wb_result);
  assign fwd_b_val = fwd_mux(hz.fwd_b, ex.b, memory_state.result, wb_result);

  // loads and stores use the adder for the address
  always_comb begin
    alu_op = rv_pkg::ALU_ADD;
    op_b = imm_i;
    rd_we = 1'b0;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        alu_op = rv_pkg::ALU_PASS_B;
        op_b = imm_u;
        rd_we = 1'b1;
      end
      rv_pkg::OPC_LOAD: rd_we = 1'b1;
      rv_pkg::OPC_STORE: op_b = imm_s;
      rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: begin
        rd_we = 1'b1;
        if (opcode == rv_pkg::OPC_OP) begin
          op_b = fwd_b_val;
        end
        case (funct3)
          3'b000: alu_op = (opcode == rv_pkg::OPC_OP && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001: alu_op = rv_pkg::ALU_SLL;
          3'b010: alu_op = rv_pkg::ALU_SLT;
          3'b011: alu_op = rv_pkg::ALU_SLTU;
          3'b100: alu_op = rv_pkg::ALU_XOR;
          3'b101: alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'b110: alu_op = rv_pkg::ALU_OR;
          default: alu_op = rv_pkg::ALU_AND;
        endcase
      end
      // branches, ECALL and bubbles write nothing
      default: rd_we = 1'b0;
    endcase
  end

  always_comb begin
    alu_result = '0;
    case (alu_op)
      rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_result = op_a << op_b[4:0];
      rv_pkg::ALU_SLT:    alu_result[0] = $signed(op_a) < $signed(op_b);
      rv_pkg::ALU_SLTU:   alu_result[0] = op_a < op_b;
      rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:    alu_result = op_a >> op_b[4:0];
      rv_pkg::ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
      rv_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_pkg::ALU_PASS_B: alu_result = op_b;
      default:            alu_result = '0;
    endcase
  end

  // only BEQ and BNE, other funct3 values fall through
  assign hz.branch_taken = (opcode == rv_pkg::OPC_BRANCH) &&
                           ((funct3 == 3'b000 && op_a == fwd_b_val) ||
                            (funct3 == 3'b001 && op_a != fwd_b_val));
  assign redirect_pc = ex.pc + imm_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_state <= '{pc: '0, insn: '0, result: '0, store_data: '0, rd_we: 1'b0,
                        status: rv_pkg::CYCLE_RESET};
    end else begin
      memory_state <= '{pc: ex.pc, insn: ex.insn, result: alu_result, store_data: fwd_b_val,
                        rd_we: rd_we, status: ex.status};
    end
  end

  a_unknown_opcode_no_write: assert property (
    @(posedge clk) disable iff (rst)
    !(opcode inside {rv_pkg::OPC_LOAD, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP, rv_pkg::OPC_LUI})
      |=> !memory_state.rd_we
  ) else $error("register write flagged for a non-writing opcode");

endmodule

//--- rtl/mem_wb_unit.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module mem_wb_unit (
  input  logic clk,
  input  logic rst,
  hazard_if.dp hz,
  input  rv_pkg::memory_stage_t memory_state,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic dmem_we,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic [`RV_REG_IDX_W-1:0] rf_rd,
  output logic [`RV_XLEN-1:0] rf_rd_data,
  output logic rf_we,
  output logic [`RV_XLEN-1:0] wb_result,
  output logic halt,
  output logic [`RV_XLEN-1:0] trace_pc,
  output logic [`RV_XLEN-1:0] trace_insn,
  output rv_pkg::cycle_status_e trace_status
);

  rv_pkg::memory_stage_t wb;
  logic mem_is_store;

  assign mem_is_store = (memory_state.insn[6:0] == rv_pkg::OPC_STORE);

  // word-only data port
  assign dmem_addr = memory_state.result;
  assign dmem_we = mem_is_store;
  assign dmem_wdata = hz.store_fwd ? wb_result : memory_state.store_data;

  assign hz.mem_rs2 = mem_is_store ? memory_state.insn[24:20] : '0;
  assign hz.mem_rd = memory_state.insn[11:7];
  assign hz.mem_we = memory_state.rd_we;

  // the load data takes the store data slot
  always_ff @(posedge clk) begin
    if (rst) begin
      wb <= '{pc: '0, insn: '0, result: '0, store_data: '0, rd_we: 1'b0,
              status: rv_pkg::CYCLE_RESET};
    end else begin
      wb <= '{pc: memory_state.pc, insn: memory_state.insn, result: memory_state.result,
              store_data: dmem_rdata, rd_we: memory_state.rd_we, status: memory_state.status};
    end
  end

  assign wb_result = (wb.insn[6:0] == rv_pkg::OPC_LOAD) ? wb.store_data : wb.result;

  assign rf_rd = wb.insn[11:7];
  assign rf_rd_data = wb_result;
  assign rf_we = wb.rd_we;
  assign hz.wb_rd = wb.insn[11:7];
  assign hz.wb_we = wb.rd_we;

  // ECALL is the only SYSTEM instruction kept
  assign halt = (wb.insn[6:0] == rv_pkg::OPC_SYSTEM);

  assign trace_pc = wb.pc;
  assign trace_insn = wb.insn;
  assign trace_status = wb.status;

  a_store_aligned: assert property (
    @(posedge clk) disable iff (rst)
    dmem_we |-> dmem_addr[1:0] == 2'b00
  ) else $error("misaligned word store to %h", dmem_addr);

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
  input  logic clk,
  input  logic rst,
  output logic [`RV_XLEN-1:0] pc_to_imem,
  input  logic [`RV_XLEN-1:0] insn_from_imem,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic dmem_we,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic halt,
  output logic [`RV_XLEN-1:0] trace_pc,
  output logic [`RV_XLEN-1:0] trace_insn,
  output rv_pkg::cycle_status_e trace_status
);

  rv_pkg::decode_stage_t decode_state;
  rv_pkg::memory_stage_t memory_state;
  logic [`RV_XLEN-1:0] redirect_pc;
  logic [`RV_REG_IDX_W-1:0] rf_rs1;
  logic [`RV_REG_IDX_W-1:0] rf_rs2;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_REG_IDX_W-1:0] rf_rd;
  logic [`RV_XLEN-1:0] rf_rd_data;
  logic rf_we;
  logic [`RV_XLEN-1:0] wb_result;

  hazard_if hz_if ();

  hazard_ctrl u_hazard_ctrl (.clk(clk), .rst(rst), .hz(hz_if.ctrl));

  fetch_unit u_fetch (
    .clk(clk), .rst(rst), .hz(hz_if.dp),
    .redirect_pc(redirect_pc),
    .insn_from_imem(insn_from_imem),
    .pc_to_imem(pc_to_imem),
    .decode_state(decode_state)
  );

  reg_file u_reg_file (
    .clk(clk), .rst(rst),
    .rs1(rf_rs1), .rs2(rf_rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rd(rf_rd), .rd_data(rf_rd_data), .we(rf_we)
  );

  exec_unit u_exec (
    .clk(clk), .rst(rst), .hz(hz_if.dp),
    .decode_state(decode_state),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rf_rs1(rf_rs1), .rf_rs2(rf_rs2),
    .wb_result(wb_result),
    .redirect_pc(redirect_pc),
    .memory_state(memory_state)
  );

  mem_wb_unit u_mem_wb (
    .clk(clk), .rst(rst), .hz(hz_if.dp),
    .memory_state(memory_state),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata),
    .rf_rd(rf_rd), .rf_rd_data(rf_rd_data), .rf_we(rf_we),
    .wb_result(wb_result),
    .halt(halt),
    .trace_pc(trace_pc), .trace_insn(trace_insn), .trace_status(trace_status)
  );

endmodule

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 128;
  localparam logic [6:0] OPC_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LOAD = 7'b000_0011;
  localparam logic [31:0] NOP = 32'h0000_0013;
  localparam logic [31:0] ECALL = 32'h0000_0073;

  logic clk;
  logic rst;
  logic [31:0] pc_to_imem;
  logic [31:0] insn_from_imem;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic dmem_we;
  logic [31:0] dmem_rdata;
  logic halt;
  logic [31:0] trace_pc;
  logic [31:0] trace_insn;
  rv_pkg::cycle_status_e trace_status;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];

  // program words, the pcs of the executed path and the expected stores in order
  logic [31:0] prog_q [$];
  logic [31:0] path_q [$];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];

  int errors = 0;
  int store_idx = 0;
  int path_idx = 0;
  int post_rst = 0;
  int load2use_cnt = 0;
  int taken_cnt = 0;
  bit run_done = 1'b0;

  rv_core u_dut (
    .clk(clk), .rst(rst),
    .pc_to_imem(pc_to_imem), .insn_from_imem(insn_from_imem),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata), .halt(halt),
    .trace_pc(trace_pc), .trace_insn(trace_insn), .trace_status(trace_status)
  );

  always #5 clk = ~clk;

  // both memories answer in the same cycle
  assign insn_from_imem = imem[pc_to_imem[7:2]];
  assign dmem_rdata = dmem[dmem_addr[8:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[8:2]] <= dmem_wdata;
    end
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b011_0011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b010_0011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b110_0011};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b011_0111};
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic put_insn(input logic [31:0] word, input bit on_path);
    if (on_path) begin
      path_q.push_back(prog_q.size() * 4);
    end
    prog_q.push_back(word);
  endtask

  // word store from x0 plus offset, expected only when it lies on the executed path
  task automatic put_store(input logic [4:0] rs2, input logic [11:0] offset,
                           input logic [31:0] data, input bit on_path);
    put_insn(s_type(offset, rs2, 5'd0), on_path);
    if (on_path) begin
      exp_addr_q.push_back({20'b0, offset});
      exp_data_q.push_back(data);
    end
  endtask

  task automatic build_tables();
    // x1 = 8000_0000, x2 = -5, x3 = 7
    put_insn(lui_word(20'h80000, 5'd1), 1'b1);
    put_insn(i_type(12'hffb, 5'd0, 3'b000, 5'd2, OPC_IMM), 1'b1);
    put_insn(i_type(12'h007, 5'd0, 3'b000, 5'd3, OPC_IMM), 1'b1);
    put_store(5'd1, 12'h100, 32'h8000_0000, 1'b1);
    // signed and unsigned compare of -5 against 7
    put_insn(r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd4), 1'b1);
    put_store(5'd4, 12'h104, 32'h0000_0001, 1'b1);
    put_insn(r_type(7'h00, 5'd3, 5'd2, 3'b011, 5'd5), 1'b1);
    put_store(5'd5, 12'h108, 32'h0000_0000, 1'b1);
    // srai and srli by 4
    put_insn(i_type(12'h404, 5'd1, 3'b101, 5'd6, OPC_IMM), 1'b1);
    put_insn(i_type(12'h004, 5'd1, 3'b101, 5'd7, OPC_IMM), 1'b1);
    put_store(5'd6, 12'h10c, 32'hf800_0000, 1'b1);
    put_store(5'd7, 12'h110, 32'h0800_0000, 1'b1);
    // xori ori andi sub sll srl, each using the result just before it
    put_insn(i_type(12'h0f0, 5'd3, 3'b100, 5'd8, OPC_IMM), 1'b1);
    put_insn(i_type(12'hf00, 5'd8, 3'b110, 5'd9, OPC_IMM), 1'b1);
    put_insn(i_type(12'h7ff, 5'd9, 3'b111, 5'd10, OPC_IMM), 1'b1);
    put_insn(r_type(7'h20, 5'd3, 5'd10, 3'b000, 5'd11), 1'b1);
    put_insn(r_type(7'h00, 5'd3, 5'd11, 3'b001, 5'd12), 1'b1);
    put_insn(r_type(7'h00, 5'd3, 5'd12, 3'b101, 5'd13), 1'b1);
    // sra add or and xor
    put_insn(r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd14), 1'b1);
    put_insn(r_type(7'h00, 5'd14, 5'd13, 3'b000, 5'd15), 1'b1);
    put_insn(r_type(7'h00, 5'd1, 5'd15, 3'b110, 5'd16), 1'b1);
    put_insn(r_type(7'h00, 5'd9, 5'd16, 3'b111, 5'd17), 1'b1);
    put_insn(r_type(7'h00, 5'd2, 5'd17, 3'b100, 5'd18), 1'b1);
    put_store(5'd8, 12'h114, 32'h0000_00f7, 1'b1);
    put_store(5'd12, 12'h118, 32'h0003_f800, 1'b1);
    put_store(5'd14, 12'h11c, 32'hffff_ffff, 1'b1);
    put_store(5'd18, 12'h120, 32'h7fff_f81c, 1'b1);
    // load with an immediate use
    put_store(5'd16, 12'h124, 32'h8000_07ef, 1'b1);
    put_insn(i_type(12'h124, 5'd0, 3'b010, 5'd19, OPC_LOAD), 1'b1);
    put_insn(i_type(12'h001, 5'd19, 3'b000, 5'd20, OPC_IMM), 1'b1);
    put_store(5'd20, 12'h128, 32'h8000_07f0, 1'b1);
    // beq and bne that fall through
    put_insn(b_type(13'd8, 5'd20, 5'd3, 3'b000), 1'b1);
    put_store(5'd3, 12'h12c, 32'h0000_0007, 1'b1);
    put_insn(b_type(13'd8, 5'd3, 5'd3, 3'b001), 1'b1);
    put_store(5'd4, 12'h130, 32'h0000_0001, 1'b1);
    // taken beq skips two stores, taken bne skips one
    put_insn(i_type(12'h007, 5'd0, 3'b000, 5'd21, OPC_IMM), 1'b1);
    put_insn(b_type(13'd12, 5'd3, 5'd21, 3'b000), 1'b1);
    put_store(5'd1, 12'h134, 32'h0, 1'b0);
    put_store(5'd2, 12'h138, 32'h0, 1'b0);
    put_insn(i_type(12'h055, 5'd0, 3'b000, 5'd22, OPC_IMM), 1'b1);
    put_insn(b_type(13'd8, 5'd3, 5'd22, 3'b001), 1'b1);
    put_store(5'd22, 12'h13c, 32'h0, 1'b0);
    put_store(5'd22, 12'h140, 32'h0000_0055, 1'b1);
    put_insn(ECALL, 1'b1);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    void'($urandom(32'h19bcac6b));
    build_tables();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog_q.size()) ? prog_q[i] : NOP;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = $urandom;
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    wait (run_done);
    if (store_idx != exp_addr_q.size()) begin
      $display("halt raised with %0d of %0d expected stores seen",
               store_idx, exp_addr_q.size());
      errors++;
    end
    if (path_idx != path_q.size()) begin
      $display("trace stopped after %0d of %0d executed instructions",
               path_idx, path_q.size());
      errors++;
    end
    check_value(trace_insn, ECALL, "instruction in writeback at halt");
    check_value(load2use_cnt, 32'd1, "load-use bubbles on trace");
    // two bubbles for each of the two taken branches
    check_value(taken_cnt, 32'd4, "taken-branch bubbles on trace");
    $display("errors: %0d, stores checked: %0d of %0d",
             errors, store_idx, exp_addr_q.size());
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // four cycles per program word plus slack for fill and bubbles
  initial begin
    #1;
    repeat (prog_q.size() * 4 + 50) @(posedge clk);
    $display("timeout: halt was never raised");
    $display("Simulation failed");
    $finish;
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst || post_rst < 4) begin
      check_value({31'b0, dmem_we}, 32'd0, "dmem_we during reset");
      check_value({31'b0, halt}, 32'd0, "halt during reset");
      check_value({29'b0, trace_status}, {29'b0, rv_pkg::CYCLE_RESET}, "reset trace status");
      check_value(trace_pc, 32'h0, "reset trace pc");
      check_value(trace_insn, 32'h0, "reset trace instruction");
      // fetch starts at zero and steps one word per edge once reset is gone
      check_value(pc_to_imem, post_rst * 4, "fetch pc around reset");
      if (!rst) begin
        post_rst++;
      end
    end else if (!run_done) begin
      if (dmem_we) begin
        if (store_idx < exp_addr_q.size()) begin
          check_value(dmem_addr, exp_addr_q[store_idx], "store address");
          check_value(dmem_wdata, exp_data_q[store_idx], "store data");
          store_idx++;
        end else begin
          $display("unexpected extra store to %h at %0t", dmem_addr, $time);
          errors++;
        end
      end
      case (trace_status)
        rv_pkg::CYCLE_LOAD2USE: load2use_cnt++;
        rv_pkg::CYCLE_TAKEN_BRANCH: taken_cnt++;
        rv_pkg::CYCLE_NO_STALL: begin
          if (path_idx < path_q.size()) begin
            check_value(trace_pc, path_q[path_idx], "trace pc");
            check_value(trace_insn, prog_q[path_q[path_idx] >> 2], "trace instruction");
            path_idx++;
          end else begin
            $display("trace went past the end of the program at %0t", $time);
            errors++;
          end
        end
        default: begin
          $display("trace status %0d is not allowed after reset, at %0t", trace_status, $time);
          errors++;
        end
      endcase
      if (halt) begin
        run_done = 1'b1;
      end
    end
  end

endmodule

//--- src.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/hazard_if.sv
rtl/hazard_ctrl.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/mem_wb_unit.sv
rtl/rv_core.sv
bench/tb_rv_core.sv
